/* design/mux_pkg.sv */
// Shared widths, opcode enums and request and response structs for the two-port host mux
package mux_pkg;

    // ========================================
    // Field widths
    // ========================================

    // One data line as carried on the write and read data paths
    localparam int LINE_BITS  = 64;
    localparam int ADDR_BITS  = 32;
    // Mdata is returned untouched by the host, so one bit of it routes responses
    localparam int MDATA_BITS = 12;
    // The routing tag is a single bit, so the mux is fixed at two clients
    localparam int NUM_AFU    = 2;

    // ========================================
    // Opcodes
    // ========================================

    typedef enum logic [1:0] {
        C1_WR_LINE,
        C1_INTR
    } c1_op_e;

    // Config writes originate at the host and carry no meaningful tag
    typedef enum logic [1:0] {
        RSP_RD,
        RSP_WR,
        RSP_CFG
    } rsp_kind_e;

    // ========================================
    // Request and response bundles
    // ========================================

    typedef struct packed {
        logic [ADDR_BITS-1:0]  addr;
        logic [MDATA_BITS-1:0] mdata;
    } tx_hdr_t;

    typedef struct packed {
        logic    valid;
        tx_hdr_t hdr;
    } c0_tx_t;

    typedef struct packed {
        logic                 valid;
        c1_op_e               op;
        tx_hdr_t              hdr;
        logic [LINE_BITS-1:0] data;
    } c1_tx_t;

    typedef struct packed {
        rsp_kind_e             kind;
        logic [MDATA_BITS-1:0] mdata;
    } rx_hdr_t;

    typedef struct packed {
        logic                 valid;
        rx_hdr_t              hdr;
        logic [LINE_BITS-1:0] data;
    } c0_rx_t;

    typedef struct packed {
        logic    valid;
        rx_hdr_t hdr;
    } c1_rx_t;

endpackage

/* design/afu_req_buffer.sv */
// AFU request buffer holding one FIFO per channel and reporting its own almost-full level
`timescale 1ns/1ps

module afu_req_buffer
    import mux_pkg::*;
#(
    parameter int BUF_DEPTH = 4
)
(
    input  logic   clk,
    input  logic   resetb,
    input  c0_tx_t afu_c0_tx,
    input  c1_tx_t afu_c1_tx,
    input  logic   deq_c0,
    input  logic   deq_c1,
    output c0_tx_t buf_c0,
    output c1_tx_t buf_c1,
    output logic   c0_alm_full,
    output logic   c1_alm_full
);

    localparam int PTR_BITS = $clog2(BUF_DEPTH);
    // One extra bit so a full FIFO is distinct from an empty one
    localparam int CNT_BITS = PTR_BITS + 1;
    localparam logic [CNT_BITS-1:0] FULL_LEVEL = CNT_BITS'(BUF_DEPTH);
    // Two slots of slack cover requests already in flight from the AFU
    localparam logic [CNT_BITS-1:0] ALM_LEVEL  = CNT_BITS'(BUF_DEPTH - 2);

    c0_tx_t              c0_mem [BUF_DEPTH];
    logic [PTR_BITS-1:0] c0_wr_ptr;
    logic [PTR_BITS-1:0] c0_rd_ptr;
    logic [CNT_BITS-1:0] c0_count;

    c1_tx_t              c1_mem [BUF_DEPTH];
    logic [PTR_BITS-1:0] c1_wr_ptr;
    logic [PTR_BITS-1:0] c1_rd_ptr;
    logic [CNT_BITS-1:0] c1_count;

    // ========================================
    // Storage, written on every AFU strobe
    // ========================================

    always_ff @(posedge clk)
    begin
        if (afu_c0_tx.valid)
            c0_mem[c0_wr_ptr] <= afu_c0_tx;
        if (afu_c1_tx.valid)
            c1_mem[c1_wr_ptr] <= afu_c1_tx;
    end

    // Pointers wrap naturally because the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            c0_wr_ptr <= '0;
            c0_rd_ptr <= '0;
            c0_count  <= '0;
            c1_wr_ptr <= '0;
            c1_rd_ptr <= '0;
            c1_count  <= '0;
        end
        else
        begin
            c0_wr_ptr <= c0_wr_ptr + PTR_BITS'(afu_c0_tx.valid);
            c0_rd_ptr <= c0_rd_ptr + PTR_BITS'(deq_c0);
            c0_count  <= c0_count + CNT_BITS'(afu_c0_tx.valid) - CNT_BITS'(deq_c0);
            c1_wr_ptr <= c1_wr_ptr + PTR_BITS'(afu_c1_tx.valid);
            c1_rd_ptr <= c1_rd_ptr + PTR_BITS'(deq_c1);
            c1_count  <= c1_count + CNT_BITS'(afu_c1_tx.valid) - CNT_BITS'(deq_c1);
        end
    end

    // Head of each FIFO, valid whenever something is stored
    always_comb
    begin
        buf_c0       = c0_mem[c0_rd_ptr];
        buf_c0.valid = (c0_count != '0);
        buf_c1       = c1_mem[c1_rd_ptr];
        buf_c1.valid = (c1_count != '0);
    end

    assign c0_alm_full = (c0_count >= ALM_LEVEL);
    assign c1_alm_full = (c1_count >= ALM_LEVEL);

    // The AFU must have honoured the almost-full level
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetb)
        (afu_c0_tx.valid |-> c0_count != FULL_LEVEL) and
        (afu_c1_tx.valid |-> c1_count != FULL_LEVEL));

    // The arbiter only pops a port that presented a valid head
    a_no_underflow: assert property (@(posedge clk) disable iff (!resetb)
        (deq_c0 |-> c0_count != '0) and (deq_c1 |-> c1_count != '0));

endmodule

/* design/req_arbiter.sv */
// Round-robin request arbiter that tags the winning port into Mdata and issues to the host
`timescale 1ns/1ps

module req_arbiter
    import mux_pkg::*;
#(
    parameter int MUX_MDATA_IDX = 11
)
(
    input  logic   clk,
    input  logic   resetb,
    input  c0_tx_t buf_c0 [NUM_AFU],
    input  c1_tx_t buf_c1 [NUM_AFU],
    input  logic   host_c0_alm_full,
    input  logic   host_c1_alm_full,
    output c0_tx_t host_c0_tx,
    output c1_tx_t host_c1_tx,
    output logic   deq_c0 [NUM_AFU],
    output logic   deq_c1 [NUM_AFU]
);

    // Pending heads per channel, bit p set when port p has a request
    logic [NUM_AFU-1:0] c0_req;
    logic [NUM_AFU-1:0] c1_req;

    // Winner index per channel, one bit since there are two ports
    logic c0_win;
    logic c1_win;
    logic last_c0_win;
    logic last_c1_win;

    // A request goes out only when someone is pending and the host has room
    logic c0_issue;
    logic c1_issue;

    assign c0_req = {buf_c0[1].valid, buf_c0[0].valid};
    assign c1_req = {buf_c1[1].valid, buf_c1[0].valid};

    // ========================================
    // Winner selection
    // ========================================

    // Port 1 wins when it is alone, or when both pend and port 0 went last
    assign c0_win = c0_req[1] && (!c0_req[0] || (last_c0_win == 1'b0));
    assign c1_win = c1_req[1] && (!c1_req[0] || (last_c1_win == 1'b0));

    assign c0_issue = (|c0_req) && !host_c0_alm_full;
    assign c1_issue = (|c1_req) && !host_c1_alm_full;

    // History only moves on an actual issue, so a stalled host keeps the order
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            last_c0_win <= 1'b0;
            last_c1_win <= 1'b0;
        end
        else
        begin
            if (c0_issue)
                last_c0_win <= c0_win;
            if (c1_issue)
                last_c1_win <= c1_win;
        end
    end

    // ========================================
    // Host request path
    // ========================================

    // The payload follows the winner; only valid carries the issue decision
    always_comb
    begin
        host_c0_tx                          = buf_c0[c0_win];
        host_c0_tx.hdr.mdata[MUX_MDATA_IDX] = c0_win;
        host_c0_tx.valid                    = c0_issue;

        host_c1_tx                          = buf_c1[c1_win];
        host_c1_tx.hdr.mdata[MUX_MDATA_IDX] = c1_win;
        host_c1_tx.valid                    = c1_issue;
    end

    // Pop the winning buffer in the same cycle as the issue
    for (genvar p = 0; p < NUM_AFU; p++)
    begin : g_deq
        assign deq_c0[p] = c0_issue && (c0_win == 1'(p));
        assign deq_c1[p] = c1_issue && (c1_win == 1'(p));
    end

    // AFUs must leave the routing bit clear, or responses would go astray
    a_tag_clear: assert property (@(posedge clk) disable iff (!resetb)
        (c0_issue |-> !buf_c0[c0_win].hdr.mdata[MUX_MDATA_IDX]) and
        (c1_issue |-> !buf_c1[c1_win].hdr.mdata[MUX_MDATA_IDX]));

    // Bit 0 stays with the AFU, the tag must land inside the Mdata field
    a_idx_legal: assert property (@(posedge clk)
        (MUX_MDATA_IDX > 0) && (MUX_MDATA_IDX < MDATA_BITS));

endmodule

/* design/rsp_router.sv */
// Host response router that steers valids by the Mdata tag and broadcasts config writes
`timescale 1ns/1ps

module rsp_router
    import mux_pkg::*;
#(
    parameter int MUX_MDATA_IDX = 11
)
(
    input  c0_rx_t host_c0_rx,
    input  c1_rx_t host_c1_rx,
    output c0_rx_t afu_c0_rx [NUM_AFU],
    output c1_rx_t afu_c1_rx [NUM_AFU]
);

    // Owning port of each response, as written by the arbiter on issue
    logic c0_owner;
    logic c1_owner;

    // Config writes come from the host itself and reach every AFU
    logic c0_bcast;
    logic c1_bcast;

    assign c0_owner = host_c0_rx.hdr.mdata[MUX_MDATA_IDX];
    assign c1_owner = host_c1_rx.hdr.mdata[MUX_MDATA_IDX];

    assign c0_bcast = (host_c0_rx.hdr.kind == RSP_CFG);
    assign c1_bcast = (host_c1_rx.hdr.kind == RSP_CFG);

    // ========================================
    // Per-port copies
    // ========================================

    // Header and data go everywhere, valid decides who actually sees it
    always_comb
    begin
        for (int p = 0; p < NUM_AFU; p++)
        begin
            afu_c0_rx[p] = host_c0_rx;
            // The AFU sent this bit as zero, so zero is what it gets back
            afu_c0_rx[p].hdr.mdata[MUX_MDATA_IDX] = 1'b0;
            afu_c0_rx[p].valid = host_c0_rx.valid &&
                                 (c0_bcast || (c0_owner == 1'(p)));

            afu_c1_rx[p] = host_c1_rx;
            afu_c1_rx[p].hdr.mdata[MUX_MDATA_IDX] = 1'b0;
            afu_c1_rx[p].valid = host_c1_rx.valid &&
                                 (c1_bcast || (c1_owner == 1'(p)));
        end
    end

    // Read and write completions carry a tag set by the arbiter,
    // so at most one port sees each of them
    // Config writes are the only responses that land at both ports

endmodule

/* design/host_mux_top.sv */
// Two-client host mux top level joining the request buffers, arbiter and response router
`timescale 1ns/1ps

module host_mux_top
    import mux_pkg::*;
#(
    parameter int MUX_MDATA_IDX = 11,
    parameter int BUF_DEPTH     = 4
)
(
    input  logic   clk,
    input  logic   resetb,
    input  c0_tx_t afu_c0_tx [NUM_AFU],
    input  c1_tx_t afu_c1_tx [NUM_AFU],
    output logic   afu_c0_alm_full [NUM_AFU],
    output logic   afu_c1_alm_full [NUM_AFU],
    output c0_rx_t afu_c0_rx [NUM_AFU],
    output c1_rx_t afu_c1_rx [NUM_AFU],
    output c0_tx_t host_c0_tx,
    output c1_tx_t host_c1_tx,
    input  logic   host_c0_alm_full,
    input  logic   host_c1_alm_full,
    input  c0_rx_t host_c0_rx,
    input  c1_rx_t host_c1_rx
);

    // Buffer heads seen by the arbiter, and its pop strobes back
    c0_tx_t buf_c0 [NUM_AFU];
    c1_tx_t buf_c1 [NUM_AFU];
    logic   deq_c0 [NUM_AFU];
    logic   deq_c1 [NUM_AFU];

    // ========================================
    // Request side
    // ========================================

    // Each AFU gets its own buffer so host almost-full never reaches it
    for (genvar p = 0; p < NUM_AFU; p++)
    begin : g_buf
        afu_req_buffer #(
            .BUF_DEPTH (BUF_DEPTH)
        ) afu_req_buffer_i (
            .clk         (clk),
            .resetb      (resetb),
            .afu_c0_tx   (afu_c0_tx[p]),
            .afu_c1_tx   (afu_c1_tx[p]),
            .deq_c0      (deq_c0[p]),
            .deq_c1      (deq_c1[p]),
            .buf_c0      (buf_c0[p]),
            .buf_c1      (buf_c1[p]),
            .c0_alm_full (afu_c0_alm_full[p]),
            .c1_alm_full (afu_c1_alm_full[p])
        );
    end

    req_arbiter #(
        .MUX_MDATA_IDX (MUX_MDATA_IDX)
    ) req_arbiter_i (
        .clk              (clk),
        .resetb           (resetb),
        .buf_c0           (buf_c0),
        .buf_c1           (buf_c1),
        .host_c0_alm_full (host_c0_alm_full),
        .host_c1_alm_full (host_c1_alm_full),
        .host_c0_tx       (host_c0_tx),
        .host_c1_tx       (host_c1_tx),
        .deq_c0           (deq_c0),
        .deq_c1           (deq_c1)
    );

    // ========================================
    // Response side
    // ========================================

    rsp_router #(
        .MUX_MDATA_IDX (MUX_MDATA_IDX)
    ) rsp_router_i (
        .host_c0_rx (host_c0_rx),
        .host_c1_rx (host_c1_rx),
        .afu_c0_rx  (afu_c0_rx),
        .afu_c1_rx  (afu_c1_rx)
    );

endmodule

/* bench/tb_clock_gen.sv */
// Testbench clock and reset source with an 8 ns clock and a 10 cycle active-low reset
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic resetb
);

    // Half of the 8 ns period
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release falls between edges so the synchronous reset ends cleanly
    initial
    begin
        resetb = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;
    end

endmodule

/* bench/tb_host_mux.sv */
// Testbench for the two-port host mux, checking arbitration, tagging and response routing
`timescale 1ns/1ps

module tb_host_mux
    import mux_pkg::*;
();

    localparam int MUX_MDATA_IDX = 11;
    localparam int BUF_DEPTH     = 4;

    logic   clk;
    logic   resetb;
    c0_tx_t afu_c0_tx [NUM_AFU];
    c1_tx_t afu_c1_tx [NUM_AFU];
    logic   afu_c0_alm_full [NUM_AFU];
    logic   afu_c1_alm_full [NUM_AFU];
    c0_rx_t afu_c0_rx [NUM_AFU];
    c1_rx_t afu_c1_rx [NUM_AFU];
    c0_tx_t host_c0_tx;
    c1_tx_t host_c1_tx;
    logic   host_c0_alm_full;
    logic   host_c1_alm_full;
    c0_rx_t host_c0_rx;
    c1_rx_t host_c1_rx;

    // Requests sent by each AFU and not yet seen at the host, in send order
    c0_tx_t sent_c0 [NUM_AFU][$];
    c1_tx_t sent_c1 [NUM_AFU][$];
    // Port tags of channel 0 issues, in issue order
    logic   c0_tags [$];

    logic [31:0] lfsr_state;
    int checks;
    int errors;
    int test_errs;
    int tests_run;
    int tests_bad;

    tb_clock_gen tb_clock_gen_i (
        .clk    (clk),
        .resetb (resetb)
    );

    host_mux_top #(
        .MUX_MDATA_IDX (MUX_MDATA_IDX),
        .BUF_DEPTH     (BUF_DEPTH)
    ) host_mux_top_i (
        .clk              (clk),
        .resetb           (resetb),
        .afu_c0_tx        (afu_c0_tx),
        .afu_c1_tx        (afu_c1_tx),
        .afu_c0_alm_full  (afu_c0_alm_full),
        .afu_c1_alm_full  (afu_c1_alm_full),
        .afu_c0_rx        (afu_c0_rx),
        .afu_c1_rx        (afu_c1_rx),
        .host_c0_tx       (host_c0_tx),
        .host_c1_tx       (host_c1_tx),
        .host_c0_alm_full (host_c0_alm_full),
        .host_c1_alm_full (host_c1_alm_full),
        .host_c0_rx       (host_c0_rx),
        .host_c1_rx       (host_c1_rx)
    );

    // ========================================
    // Random source
    // ========================================

    // Right-shifting Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // AFU requests always leave the routing bit clear
    function automatic c0_tx_t random_read();
        c0_tx_t r;
        r.valid = 1'b1;
        r.hdr.addr = ADDR_BITS'(rand_bits(ADDR_BITS));
        r.hdr.mdata = MDATA_BITS'(rand_bits(MDATA_BITS));
        r.hdr.mdata[MUX_MDATA_IDX] = 1'b0;
        return r;
    endfunction

    function automatic c1_tx_t random_write();
        c1_tx_t w;
        w.valid = 1'b1;
        w.op = (rand_bits(1) != 0) ? C1_INTR : C1_WR_LINE;
        w.hdr.addr = ADDR_BITS'(rand_bits(ADDR_BITS));
        w.hdr.mdata = MDATA_BITS'(rand_bits(MDATA_BITS));
        w.hdr.mdata[MUX_MDATA_IDX] = 1'b0;
        w.data = rand_bits(LINE_BITS);
        return w;
    endfunction

    // Host responses carry any tag value, config writes are always valid
    function automatic c0_rx_t random_c0_rsp(input logic cfg);
        c0_rx_t r;
        r.valid = cfg ? 1'b1 : 1'(rand_bits(1));
        r.hdr.kind = cfg ? RSP_CFG : ((rand_bits(1) != 0) ? RSP_WR : RSP_RD);
        r.hdr.mdata = MDATA_BITS'(rand_bits(MDATA_BITS));
        r.data = rand_bits(LINE_BITS);
        return r;
    endfunction

    function automatic c1_rx_t random_c1_rsp(input logic cfg);
        c1_rx_t r;
        r.valid = cfg ? 1'b1 : 1'(rand_bits(1));
        r.hdr.kind = cfg ? RSP_CFG : ((rand_bits(1) != 0) ? RSP_WR : RSP_RD);
        r.hdr.mdata = MDATA_BITS'(rand_bits(MDATA_BITS));
        return r;
    endfunction

    // ========================================
    // Reference model
    // ========================================

    // The host sees the AFU request unchanged except for the port index in the tag bit
    function automatic c0_tx_t exp_c0_tx(input c0_tx_t sent, input int port);
        c0_tx_t e;
        e = sent;
        e.valid = 1'b1;
        e.hdr.mdata[MUX_MDATA_IDX] = 1'(port);
        return e;
    endfunction

    function automatic c1_tx_t exp_c1_tx(input c1_tx_t sent, input int port);
        c1_tx_t e;
        e = sent;
        e.valid = 1'b1;
        e.hdr.mdata[MUX_MDATA_IDX] = 1'(port);
        return e;
    endfunction

    // A port owns a response if it is a config write or the tag names it
    function automatic c0_rx_t exp_c0_rx(input c0_rx_t host, input int port);
        c0_rx_t e;
        logic   mine;
        mine = (host.hdr.kind == RSP_CFG) || (host.hdr.mdata[MUX_MDATA_IDX] == 1'(port));
        e = host;
        e.hdr.mdata[MUX_MDATA_IDX] = 1'b0;
        e.valid = host.valid && mine;
        return e;
    endfunction

    function automatic c1_rx_t exp_c1_rx(input c1_rx_t host, input int port);
        c1_rx_t e;
        logic   mine;
        mine = (host.hdr.kind == RSP_CFG) || (host.hdr.mdata[MUX_MDATA_IDX] == 1'(port));
        e = host;
        e.hdr.mdata[MUX_MDATA_IDX] = 1'b0;
        e.valid = host.valid && mine;
        return e;
    endfunction

    // ========================================
    // Checks and reporting
    // ========================================

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        note_error();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_c0_tx(input string name, input c0_tx_t got, input c0_tx_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_c1_tx(input string name, input c1_tx_t got, input c1_tx_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_c0_rx(input string name, input c0_rx_t got, input c0_rx_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_c1_rx(input string name, input c1_rx_t got, input c1_rx_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0)
            $display("test %-12s ok", name);
        else
            $display("test %-12s %0d errors", name, test_errs);
        tests_run++;
        if (test_errs != 0)
            tests_bad++;
        test_errs = 0;
    endtask

    // ========================================
    // Host side monitor
    // ========================================

    // Matches a channel 0 issue against the oldest request of the tagged port
    task automatic watch_c0_issue();
        int     port;
        c0_tx_t sent;
        if (!host_c0_tx.valid)
            return;
        port = int'(host_c0_tx.hdr.mdata[MUX_MDATA_IDX]);
        c0_tags.push_back(host_c0_tx.hdr.mdata[MUX_MDATA_IDX]);
        if (host_c0_alm_full)
            report_error("host c0 request issued while host almost-full was high");
        if (sent_c0[port].size() == 0)
            report_error($sformatf("host c0 request for port %0d with nothing sent", port));
        else
        begin
            sent = sent_c0[port].pop_front();
            check_c0_tx("host_c0_tx", host_c0_tx, exp_c0_tx(sent, port));
        end
    endtask

    task automatic watch_c1_issue();
        int     port;
        c1_tx_t sent;
        if (!host_c1_tx.valid)
            return;
        port = int'(host_c1_tx.hdr.mdata[MUX_MDATA_IDX]);
        if (host_c1_alm_full)
            report_error("host c1 request issued while host almost-full was high");
        if (sent_c1[port].size() == 0)
            report_error($sformatf("host c1 request for port %0d with nothing sent", port));
        else
        begin
            sent = sent_c1[port].pop_front();
            check_c1_tx("host_c1_tx", host_c1_tx, exp_c1_tx(sent, port));
        end
    endtask

    // Sampled on the rising edge, before any register in the DUT moves
    always @(posedge clk)
    begin
        if (resetb)
        begin
            watch_c0_issue();
            watch_c1_issue();
            for (int p = 0; p < NUM_AFU; p++)
            begin
                check_c0_rx($sformatf("afu_c0_rx[%0d]", p), afu_c0_rx[p],
                            exp_c0_rx(host_c0_rx, p));
                check_c1_rx($sformatf("afu_c1_rx[%0d]", p), afu_c1_rx[p],
                            exp_c1_rx(host_c1_rx, p));
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    function automatic int pending_count();
        int n;
        n = 0;
        for (int p = 0; p < NUM_AFU; p++)
            n += sent_c0[p].size() + sent_c1[p].size();
        return n;
    endfunction

    // One cycle of AFU traffic; a port only sends while its buffer has room
    task automatic drive_cycle(input logic [1:0] c0_en, input logic [1:0] c1_en,
                               input logic c0_hold, input logic c1_hold);
        c0_tx_t rd;
        c1_tx_t wr;
        @(negedge clk);
        host_c0_alm_full = c0_hold;
        host_c1_alm_full = c1_hold;
        for (int p = 0; p < NUM_AFU; p++)
        begin
            rd = '0;
            wr = '0;
            if (c0_en[p] && !afu_c0_alm_full[p])
            begin
                rd = random_read();
                sent_c0[p].push_back(rd);
            end
            if (c1_en[p] && !afu_c1_alm_full[p])
            begin
                wr = random_write();
                sent_c1[p].push_back(wr);
            end
            afu_c0_tx[p] = rd;
            afu_c1_tx[p] = wr;
        end
    endtask

    task automatic drive_rsp(input int cycles, input logic cfg);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            host_c0_rx = random_c0_rsp(cfg);
            host_c1_rx = random_c1_rsp(cfg);
        end
        @(negedge clk);
        host_c0_rx = '0;
        host_c1_rx = '0;
    endtask

    // Waits run on the falling edge so the monitor has already popped
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (pending_count() != 0 && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (pending_count() != 0)
            report_error($sformatf("timed out after %0d cycles, %0d requests never reached the host",
                                   limit, pending_count()));
    endtask

    task automatic wait_tags(input int count, input int limit);
        int n;
        n = 0;
        while (c0_tags.size() < count && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (c0_tags.size() < count)
            report_error($sformatf("timed out waiting for %0d c0 issues, saw %0d",
                                   count, c0_tags.size()));
    endtask

    initial
    begin
        int   n;
        int   gap0;
        int   gap1;
        logic hold0;
        logic hold1;
        logic last;
        lfsr_state = 32'hc5a60200;
        checks = 0;
        errors = 0;
        test_errs = 0;
        tests_run = 0;
        tests_bad = 0;
        for (int p = 0; p < NUM_AFU; p++)
        begin
            afu_c0_tx[p] = '0;
            afu_c1_tx[p] = '0;
        end
        host_c0_alm_full = 1'b0;
        host_c1_alm_full = 1'b0;
        host_c0_rx = '0;
        host_c1_rx = '0;

        n = 0;
        while (resetb !== 1'b1 && n < 100)
        begin
            @(negedge clk);
            n++;
        end
        if (resetb !== 1'b1)
            report_error("reset never released");

        // Everything idle straight out of reset
        @(negedge clk);
        check_flag("host_c0_tx.valid", host_c0_tx.valid, 1'b0);
        check_flag("host_c1_tx.valid", host_c1_tx.valid, 1'b0);
        for (int p = 0; p < NUM_AFU; p++)
        begin
            check_flag($sformatf("afu_c0_rx[%0d].valid", p), afu_c0_rx[p].valid, 1'b0);
            check_flag($sformatf("afu_c1_rx[%0d].valid", p), afu_c1_rx[p].valid, 1'b0);
            check_flag($sformatf("afu_c0_alm_full[%0d]", p), afu_c0_alm_full[p], 1'b0);
            check_flag($sformatf("afu_c1_alm_full[%0d]", p), afu_c1_alm_full[p], 1'b0);
        end
        end_test("reset");

        // Both ports load two reads behind a stalled host
        // Last winner is 0 from reset, so port 1 goes first and the ports alternate
        c0_tags.delete();
        drive_cycle(2'b11, 2'b00, 1'b1, 1'b0);
        drive_cycle(2'b11, 2'b00, 1'b1, 1'b0);
        drive_cycle(2'b00, 2'b00, 1'b1, 1'b0);
        // Two stored reads per buffer against a level of depth minus two
        for (int p = 0; p < NUM_AFU; p++)
            check_flag($sformatf("afu_c0_alm_full[%0d]", p), afu_c0_alm_full[p],
                       1'(2 >= BUF_DEPTH - 2));
        drive_cycle(2'b00, 2'b00, 1'b0, 1'b0);
        wait_tags(4, 50);
        last = 1'b0;
        for (int i = 0; i < 4 && i < c0_tags.size(); i++)
        begin
            check_flag($sformatf("c0 issue %0d tag", i), c0_tags[i], !last);
            last = !last;
        end
        wait_drain(50);
        end_test("fairness");

        // One port at a time, both channels, both write opcodes
        for (int p = 0; p < NUM_AFU; p++)
        begin
            for (int i = 0; i < 24; i++)
                drive_cycle(2'(rand_bits(1)) << p, 2'(rand_bits(1)) << p, 1'b0, 1'b0);
        end
        drive_cycle(2'b00, 2'b00, 1'b0, 1'b0);
        wait_drain(100);
        end_test("single_port");

        // Random traffic from both ports under a randomly toggling host stall
        gap0 = 0;
        gap1 = 0;
        hold0 = 1'b0;
        hold1 = 1'b0;
        for (int i = 0; i < 300; i++)
        begin
            if (gap0 == 0)
            begin
                hold0 = !hold0;
                gap0 = int'(rand_bits(3)) + 1;
            end
            else
                gap0--;
            if (gap1 == 0)
            begin
                hold1 = !hold1;
                gap1 = int'(rand_bits(3)) + 1;
            end
            else
                gap1--;
            drive_cycle(2'(rand_bits(2)), 2'(rand_bits(2)), hold0, hold1);
        end
        drive_cycle(2'b00, 2'b00, 1'b0, 1'b0);
        wait_drain(200);
        end_test("backpressure");

        // Read and write completions with random tags, checked by the monitor
        drive_rsp(64, 1'b0);
        end_test("rsp_route");

        drive_rsp(16, 1'b1);
        end_test("cfg_bcast");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && pending_count() == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verilog.f */
design/mux_pkg.sv
design/afu_req_buffer.sv
design/req_arbiter.sv
design/rsp_router.sv
design/host_mux_top.sv
bench/tb_clock_gen.sv
bench/tb_host_mux.sv

/* run_sim.sh */
#!/bin/sh
# Builds the host mux testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_host_mux -f verilog.f -o sim_host_mux
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_host_mux > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
